// File: Bender.yml
package:
  name: board_display

sources:
  - design/board_pkg.sv
  - design/uart_rx.sv
  - design/cmd_ctrl.sv
  - design/machine_timer.sv
  - design/seg_scan.sv
  - design/board_top.sv
  - target: simulation
    files:
      - sim/board_tb.sv

// File: board_display.f
design/board_pkg.sv
design/uart_rx.sv
design/cmd_ctrl.sv
design/machine_timer.sv
design/seg_scan.sv
design/board_top.sv
sim/board_tb.sv

// File: design/board_pkg.sv
`default_nettype none

package board_pkg;

  // widths that carry a meaning on the board
  typedef logic [7:0]  byte_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  nibble_t;
  // segments, seg[0] = CA .. seg[6] = CG, active low
  typedef logic [6:0]  seg_t;
  // digit enables, an[k] lights digit k, active low
  typedef logic [7:0]  anode_t;

  // first byte of every 5-byte host frame
  typedef enum logic [7:0] {
    CMD_SET_CMP    = 8'h01,
    CMD_SHOW_TIME  = 8'h02,
    CMD_SHOW_CMP   = 8'h03,
    CMD_CLEAR_TIME = 8'h04
  } cmd_e;

  // frame parser
  typedef enum logic [1:0] {
    IDLE,
    DATA,
    APPLY
  } ctrl_state_e;

  // serial receiver
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // one received byte, valid is a single-cycle strobe
  typedef struct packed {
    logic  valid;
    byte_t data;
    logic  frame_err;
  } rx_byte_s;

  // controller to timer, both flags are single-cycle pulses
  typedef struct packed {
    logic  load_cmp;
    logic  clear_time;
    word_t cmp_value;
  } timer_ctl_s;

endpackage

`default_nettype wire

// File: design/board_top.sv
`timescale 1ns/100ps
`default_nettype none

module board_top
  import board_pkg::*;
#(
  parameter int CLK_PER_BIT    = 868,
  parameter int TIMER_PRESCALE = 100,
  parameter int DIGIT_CYCLES   = 100000
) (
  input  logic   clk_i,
  input  logic   reset_n,
  input  logic   uart_rx,
  output seg_t   seg,
  output anode_t an,
  output logic   led_irq,
  output logic   led_frame_err
);

  rx_byte_s   rx_byte;
  timer_ctl_s timer_ctl;
  word_t      mtime;
  word_t      mtimecmp;
  word_t      disp_word;

  // host serial in
  uart_rx #(
    .CLK_PER_BIT(CLK_PER_BIT)
  ) uart_rx_i (
    .clk_i  (clk_i),
    .reset_n(reset_n),
    .rx     (uart_rx),
    .rx_byte(rx_byte)
  );

  // frame parser and display select
  cmd_ctrl cmd_ctrl_i (
    .clk_i        (clk_i),
    .reset_n      (reset_n),
    .rx_byte      (rx_byte),
    .mtime        (mtime),
    .mtimecmp     (mtimecmp),
    .timer_ctl    (timer_ctl),
    .disp_word    (disp_word),
    .led_frame_err(led_frame_err)
  );

  machine_timer #(
    .TIMER_PRESCALE(TIMER_PRESCALE)
  ) machine_timer_i (
    .clk_i    (clk_i),
    .reset_n  (reset_n),
    .timer_ctl(timer_ctl),
    .mtime    (mtime),
    .mtimecmp (mtimecmp),
    .led_irq  (led_irq)
  );

  // eight-digit hex display
  seg_scan #(
    .DIGIT_CYCLES(DIGIT_CYCLES)
  ) seg_scan_i (
    .clk_i    (clk_i),
    .reset_n  (reset_n),
    .disp_word(disp_word),
    .seg      (seg),
    .an       (an)
  );

endmodule

`default_nettype wire

// File: design/cmd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_ctrl
  import board_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_n,
  input  rx_byte_s   rx_byte,
  input  word_t      mtime,
  input  word_t      mtimecmp,
  output timer_ctl_s timer_ctl,
  output word_t      disp_word,
  output logic       led_frame_err
);

  ctrl_state_e state;
  // command byte of the frame in flight
  byte_t       cmd_q;
  // data bytes, first received ends up in [7:0]
  word_t       data_q;
  logic [1:0]  data_cnt;
  logic        show_cmp;
  logic        apply;

  assign apply = (state == APPLY);

  // frame parser
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      state    <= IDLE;
      cmd_q    <= '0;
      data_cnt <= '0;
    end else begin
      case (state)
        // apply lasts one cycle, a byte then is a new command
        IDLE, APPLY: begin
          if (rx_byte.valid) begin
            cmd_q    <= rx_byte.data;
            data_cnt <= '0;
            state    <= DATA;
          end else begin
            state <= IDLE;
          end
        end
        DATA: begin
          if (rx_byte.valid) begin
            data_cnt <= data_cnt + 1'b1;
            // fourth data byte closes the frame
            if (data_cnt == 2'd3) begin
              state <= APPLY;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == DATA && rx_byte.valid) begin
      data_q <= {rx_byte.data, data_q[31:8]};
    end
  end

  // unknown codes fall through with no action
  assign timer_ctl.load_cmp   = apply && (cmd_q == CMD_SET_CMP);
  assign timer_ctl.clear_time = apply && (cmd_q == CMD_CLEAR_TIME);
  assign timer_ctl.cmp_value  = data_q;

  // display source select
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      show_cmp <= 1'b0;
    end else if (apply) begin
      case (cmd_q)
        CMD_SHOW_CMP:  show_cmp <= 1'b1;
        CMD_SHOW_TIME: show_cmp <= 1'b0;
        default:       show_cmp <= show_cmp;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      disp_word <= '0;
    end else begin
      disp_word <= show_cmp ? mtimecmp : mtime;
    end
  end

  // sticky until reset, the frame itself is still applied
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      led_frame_err <= 1'b0;
    end else if (rx_byte.valid && rx_byte.frame_err) begin
      led_frame_err <= 1'b1;
    end
  end

  a_ctl_exclusive: assert property (@(posedge clk_i) disable iff (!reset_n)
    !(timer_ctl.load_cmp && timer_ctl.clear_time));

  // timer takes the pulse at the next edge
  a_cmp_loaded: assert property (@(posedge clk_i) disable iff (!reset_n)
    timer_ctl.load_cmp |=> (mtimecmp == $past(timer_ctl.cmp_value)));

  a_time_cleared: assert property (@(posedge clk_i) disable iff (!reset_n)
    timer_ctl.clear_time |=> (mtime == '0));

endmodule

`default_nettype wire

// File: design/machine_timer.sv
`timescale 1ns/100ps
`default_nettype none

module machine_timer
  import board_pkg::*;
#(
  parameter int TIMER_PRESCALE = 100
) (
  input  logic       clk_i,
  input  logic       reset_n,
  input  timer_ctl_s timer_ctl,
  output word_t      mtime,
  output word_t      mtimecmp,
  output logic       led_irq
);

  localparam int PS_W = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;
  localparam logic [PS_W-1:0] PS_LAST = PS_W'(TIMER_PRESCALE - 1);

  logic [PS_W-1:0] ps_cnt;
  logic            tick;

  // one mtime step per prescaler wrap
  assign tick = (ps_cnt == PS_LAST);

  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      ps_cnt <= '0;
      mtime  <= '0;
    end else if (timer_ctl.clear_time) begin
      // restart the prescaler with the count
      ps_cnt <= '0;
      mtime  <= '0;
    end else if (tick) begin
      ps_cnt <= '0;
      // wraps at 2^32
      mtime  <= mtime + 1'b1;
    end else begin
      ps_cnt <= ps_cnt + 1'b1;
    end
  end

  // all ones keeps the irq off until the host loads a value
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      mtimecmp <= '1;
    end else if (timer_ctl.load_cmp) begin
      mtimecmp <= timer_ctl.cmp_value;
    end
  end

  // unsigned compare, one cycle late
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      led_irq <= 1'b0;
    end else begin
      led_irq <= (mtime >= mtimecmp);
    end
  end

  // without a clear, mtime never moves by more than one step
  a_time_step: assert property (@(posedge clk_i) disable iff (!reset_n)
    !timer_ctl.clear_time |=> ((mtime - $past(mtime)) inside {32'd0, 32'd1}));

endmodule

`default_nettype wire

// File: design/seg_scan.sv
`timescale 1ns/100ps
`default_nettype none

module seg_scan
  import board_pkg::*;
#(
  parameter int DIGIT_CYCLES = 100000
) (
  input  logic   clk_i,
  input  logic   reset_n,
  input  word_t  disp_word,
  output seg_t   seg,
  output anode_t an
);

  localparam int DW_W = (DIGIT_CYCLES > 1) ? $clog2(DIGIT_CYCLES) : 1;
  localparam logic [DW_W-1:0] DW_LAST = DW_W'(DIGIT_CYCLES - 1);

  logic [DW_W-1:0] dwell;
  // digit 0 is the least significant nibble
  logic [2:0]      digit;
  nibble_t         nib;

  // active low, bit 0 = CA, no decimal point
  function automatic seg_t hex_to_seg(nibble_t n);
    case (n)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'hA:    return 7'h08;
      4'hB:    return 7'h03;
      4'hC:    return 7'h46;
      4'hD:    return 7'h21;
      4'hE:    return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  assign nib = disp_word[{digit, 2'b00} +: 4];

  // dwell then step to the next digit, 7 wraps to 0
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      dwell <= '0;
      digit <= '0;
    end else if (dwell == DW_LAST) begin
      dwell <= '0;
      digit <= digit + 1'b1;
    end else begin
      dwell <= dwell + 1'b1;
    end
  end

  // segments and anode in the same register stage
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      an  <= '1;
      seg <= '1;
    end else begin
      an  <= ~(anode_t'(1) << digit);
      seg <= hex_to_seg(nib);
    end
  end

  // blank only in the first cycle out of reset
  a_one_anode: assert property (@(posedge clk_i) disable iff (!reset_n)
    $past(reset_n) |-> $onehot(~an));

  // scan moves up one digit at a time and wraps
  a_scan_order: assert property (@(posedge clk_i) disable iff (!reset_n)
    ($past(reset_n) && $past(an) != '1 && an != $past(an))
      |-> (an == {$past(an[6:0]), $past(an[7])}));

endmodule

`default_nettype wire

// File: design/uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx
  import board_pkg::*;
#(
  parameter int CLK_PER_BIT = 868
) (
  input  logic     clk_i,
  input  logic     reset_n,
  input  logic     rx,
  output rx_byte_s rx_byte
);

  localparam int CNT_W = (CLK_PER_BIT > 1) ? $clog2(CLK_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLK_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLK_PER_BIT / 2 - 1);

  // [1] is the synced line, [2] the sample before it
  logic [2:0]       rx_sync;
  logic             rx_s;
  logic             fall;
  rx_state_e        state;
  logic [CNT_W-1:0] cyc_cnt;
  logic [2:0]       bit_cnt;
  byte_t            shift_q;
  logic             valid_q;
  logic             ferr_q;

  assign rx_s = rx_sync[1];
  // start bit is a falling edge, a low stop bit never re-arms
  assign fall = rx_sync[2] & ~rx_sync[1];

  // idle line is high
  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      rx_sync <= '1;
    end else begin
      rx_sync <= {rx_sync[1:0], rx};
    end
  end

  always_ff @(posedge clk_i or negedge reset_n) begin
    if (!reset_n) begin
      state   <= RX_IDLE;
      cyc_cnt <= '0;
      bit_cnt <= '0;
      valid_q <= 1'b0;
      ferr_q  <= 1'b0;
    end else begin
      // strobes by default
      valid_q <= 1'b0;
      ferr_q  <= 1'b0;
      case (state)
        RX_IDLE: begin
          cyc_cnt <= '0;
          bit_cnt <= '0;
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (cyc_cnt == HALF_LAST) begin
            cyc_cnt <= '0;
            // line high again at mid-bit means a glitch
            state   <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (cyc_cnt == BIT_LAST) begin
            cyc_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= RX_STOP;
            end
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (cyc_cnt == BIT_LAST) begin
            // byte goes out even with a bad stop bit
            valid_q <= 1'b1;
            ferr_q  <= ~rx_s;
            state   <= RX_IDLE;
          end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb first, shifts in from the top
  always_ff @(posedge clk_i) begin
    if (state == RX_DATA && cyc_cnt == BIT_LAST) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign rx_byte = '{valid: valid_q, data: shift_q, frame_err: ferr_q};

  // a frame lasts ten bits, so the strobe never repeats back to back
  a_valid_strobe: assert property (@(posedge clk_i) disable iff (!reset_n)
    rx_byte.valid |=> !rx_byte.valid);

  a_state_legal: assert property (@(posedge clk_i) disable iff (!reset_n)
    state inside {RX_IDLE, RX_START, RX_DATA, RX_STOP});

endmodule

`default_nettype wire

// File: sim/board_tb.sv
`timescale 1ns/100ps
`default_nettype none

module board_tb
  import board_pkg::*;
();

  localparam int CLK_PER_BIT    = 8;
  localparam int TIMER_PRESCALE = 4;
  localparam int DIGIT_CYCLES   = 4;
  // one 5-byte frame on the line, ten bits per byte
  localparam int FRAME_CYCLES   = 5 * 10 * CLK_PER_BIT;
  // about 21 frames plus display reads and the irq wait, doubled
  localparam int TIMEOUT_CYCLES = 50 * FRAME_CYCLES;

  logic        clk_i;
  logic        reset_n;
  logic        uart_rx;
  seg_t        seg;
  anode_t      an;
  logic        led_irq;
  logic        led_frame_err;
  int          cycle_cnt = 0;
  logic [31:0] lfsr_q = 32'h3b4b695b;

  board_top #(
    .CLK_PER_BIT   (CLK_PER_BIT),
    .TIMER_PRESCALE(TIMER_PRESCALE),
    .DIGIT_CYCLES  (DIGIT_CYCLES)
  ) dut_i (
    .clk_i        (clk_i),
    .reset_n      (reset_n),
    .uart_rx      (uart_rx),
    .seg          (seg),
    .an           (an),
    .led_irq      (led_irq),
    .led_frame_err(led_frame_err)
  );

  always #2 clk_i = ~clk_i;

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // watchdog
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      stop_on_error("timeout: the tests did not finish within the cycle limit");
    end
  end

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got == exp) else begin
      stop_on_error($sformatf("error: %s got %08h expected %08h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      stop_on_error($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic word_t lfsr_word();
    word_t w;
    logic  fb;
    int    i;
    w = '0;
    for (i = 0; i < 32; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      w      = {w[30:0], fb};
    end
    return w;
  endfunction

  // lit segments, bit 0 = a .. bit 6 = g
  function automatic logic [6:0] lit_pattern(nibble_t n);
    case (n)
      4'h0:    return 7'h3F;
      4'h1:    return 7'h06;
      4'h2:    return 7'h5B;
      4'h3:    return 7'h4F;
      4'h4:    return 7'h66;
      4'h5:    return 7'h6D;
      4'h6:    return 7'h7D;
      4'h7:    return 7'h07;
      4'h8:    return 7'h7F;
      4'h9:    return 7'h6F;
      4'hA:    return 7'h77;
      4'hB:    return 7'h7C;
      4'hC:    return 7'h39;
      4'hD:    return 7'h5E;
      4'hE:    return 7'h79;
      default: return 7'h71;
    endcase
  endfunction

  // reverse lookup, bit 4 set for a legal hex pattern
  function automatic logic [4:0] seg_decode(seg_t s);
    logic [4:0] r;
    int         n;
    r = '0;
    for (n = 0; n < 16; n++) begin
      if (seg_t'(~s) == lit_pattern(nibble_t'(n))) begin
        r = {1'b1, 4'(n)};
      end
    end
    return r;
  endfunction

  task automatic apply_reset();
    @(posedge clk_i);
    reset_n <= 1'b0;
    repeat (5) @(posedge clk_i);
    reset_n <= 1'b1;
  endtask

  // 8N1, start low, lsb first
  task automatic send_byte(input byte_t b, input logic bad_stop);
    logic [9:0] bits;
    int         i;
    bits = {~bad_stop, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk_i);
      uart_rx <= bits[i];
      repeat (CLK_PER_BIT - 1) @(posedge clk_i);
    end
    // receiver re-arms only on a falling edge
    if (bad_stop) begin
      @(posedge clk_i);
      uart_rx <= 1'b1;
      repeat (CLK_PER_BIT - 1) @(posedge clk_i);
    end
  endtask

  // bad_idx picks the byte with a low stop bit, -1 for none
  task automatic send_frame(input byte_t cmd, input word_t data, input int bad_idx);
    int i;
    send_byte(cmd, bad_idx == 0);
    for (i = 0; i < 4; i++) begin
      send_byte(data[8*i +: 8], bad_idx == i + 1);
    end
  endtask

  // ascending order bounds a counting value from below, descending from above
  task automatic read_display(input logic descending, output word_t w, output int stamp);
    logic [4:0] dec;
    anode_t     want;
    int         j;
    int         k;
    w     = '0;
    stamp = 0;
    // apply cycle, select and disp_word registers, then the segment stage
    repeat (4) @(posedge clk_i);
    for (j = 0; j < 8; j++) begin
      k    = descending ? 7 - j : j;
      want = ~(anode_t'(1) << k);
      do begin
        @(negedge clk_i);
      end while (an != want);
      dec = seg_decode(seg);
      assert (dec[4]) else begin
        stop_on_error($sformatf("display digit %0d shows no hex digit, seg %02h", k, seg));
      end
      w[4*k +: 4] = dec[3:0];
      if (k == 0) begin
        stamp = cycle_cnt;
      end
    end
  endtask

  task automatic test_count_after_reset();
    word_t first;
    word_t second;
    int    t_first;
    int    t_second;
    int    min_step;
    // mtimecmp is all ones out of reset
    @(negedge clk_i);
    check_bit("led_irq", led_irq, 1'b0);
    repeat (16) @(posedge clk_i);
    read_display(1'b1, first, t_first);
    repeat (100) @(posedge clk_i);
    read_display(1'b0, second, t_second);
    min_step = (t_second - t_first) / TIMER_PRESCALE - 2;
    assert (first != 0) else begin
      stop_on_error($sformatf("error: disp_word got %08h expected nonzero", first));
    end
    assert (second > first && int'(second - first) >= min_step) else begin
      stop_on_error($sformatf("error: disp_word %08h then %08h, step below %0d",
                              first, second, min_step));
    end
  endtask

  task automatic test_set_and_show();
    word_t value;
    word_t shown;
    word_t later;
    int    stamp;
    int    i;
    for (i = 0; i < 4; i++) begin
      value = lfsr_word();
      send_frame(CMD_SET_CMP, value, -1);
      // payload of a show frame is ignored
      send_frame(CMD_SHOW_CMP, 32'h5aa5_c33c, -1);
      read_display(1'b0, shown, stamp);
      check_word("disp_word", shown, value);
    end
    send_frame(CMD_SHOW_TIME, 32'h0, -1);
    read_display(1'b1, shown, stamp);
    repeat (20) @(posedge clk_i);
    read_display(1'b0, later, stamp);
    assert (later > shown) else begin
      stop_on_error($sformatf("error: disp_word %08h then %08h, not counting", shown, later));
    end
  endtask

  task automatic test_irq_compare();
    word_t shown;
    int    stamp;
    send_frame(CMD_CLEAR_TIME, 32'h0, -1);
    send_frame(CMD_SET_CMP, 32'd200, -1);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_bit("led_irq", led_irq, 1'b0);
    do begin
      @(negedge clk_i);
    end while (!led_irq);
    // display is still on mtime, two stages behind the compare
    repeat (2) @(posedge clk_i);
    read_display(1'b0, shown, stamp);
    assert (shown >= 32'd200) else begin
      stop_on_error($sformatf("error: disp_word got %08h expected at least %08h",
                              shown, 32'd200));
    end
    send_frame(CMD_SET_CMP, 32'hffff_ffff, -1);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_bit("led_irq", led_irq, 1'b0);
    send_frame(CMD_SET_CMP, 32'h0, -1);
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_bit("led_irq", led_irq, 1'b1);
  endtask

  task automatic test_clear_time();
    word_t shown;
    int    frame_end;
    int    stamp;
    int    limit;
    send_frame(CMD_CLEAR_TIME, 32'h0, -1);
    frame_end = cycle_cnt;
    read_display(1'b1, shown, stamp);
    limit = (stamp - frame_end) / TIMER_PRESCALE + 1;
    assert (shown <= word_t'(limit)) else begin
      stop_on_error($sformatf("error: disp_word got %08h expected at most %08h", shown, limit));
    end
  endtask

  task automatic test_unknown_cmd();
    word_t shown;
    word_t value;
    int    stamp;
    value = lfsr_word();
    send_frame(CMD_SET_CMP, value, -1);
    send_frame(CMD_SHOW_CMP, 32'h0, -1);
    read_display(1'b0, shown, stamp);
    check_word("disp_word", shown, value);
    // data bytes look like clear commands if the parser slips
    send_frame(8'h7E, 32'h0404_0404, -1);
    read_display(1'b0, shown, stamp);
    check_word("disp_word", shown, value);
    value = lfsr_word();
    send_frame(CMD_SET_CMP, value, -1);
    read_display(1'b0, shown, stamp);
    check_word("disp_word", shown, value);
  endtask

  task automatic test_frame_error();
    word_t value;
    word_t shown;
    int    stamp;
    check_bit("led_frame_err", led_frame_err, 1'b0);
    value = lfsr_word();
    // second data byte with a low stop bit, frame still applied
    send_frame(CMD_SET_CMP, value, 2);
    check_bit("led_frame_err", led_frame_err, 1'b1);
    read_display(1'b0, shown, stamp);
    check_word("disp_word", shown, value);
    send_frame(CMD_SHOW_TIME, 32'h0, -1);
    check_bit("led_frame_err", led_frame_err, 1'b1);
    send_frame(CMD_SHOW_CMP, 32'h0, -1);
    check_bit("led_frame_err", led_frame_err, 1'b1);
    apply_reset();
    @(negedge clk_i);
    check_bit("led_frame_err", led_frame_err, 1'b0);
  endtask

  initial begin
    clk_i   = 1'b0;
    reset_n = 1'b0;
    uart_rx = 1'b1;
    apply_reset();
    test_count_after_reset();
    test_set_and_show();
    test_irq_compare();
    test_clear_time();
    test_unknown_cmd();
    test_frame_error();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire
